// File: audio_rec.f
source/audio_pkg.sv
source/key_edge_detect.sv
source/audio_recorder.sv
source/audio_dsp.sv
source/audio_ctrl.sv
source/audio_top.sv
verif/sram_model.sv
verif/audio_tb.sv

// File: build.sh
#!/bin/sh
# compile the audio recorder testbench with Verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f audio_rec.f --top-module audio_tb \
	-Mdir "$BUILD_DIR" -o audio_tb_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator compile failed with status $status"
	exit 1
fi

"./$BUILD_DIR/audio_tb_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Regression passed" "$LOG"; then
	exit 0
fi
echo "pass line not found in $LOG"
exit 1

// File: source/audio_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module audio_ctrl #(
	parameter int ADDR_W       = 20,
	parameter int TICK_SAMPLES = 48000
) (
	input  logic                   i_clk,
	input  logic                   i_rst_n,
	input  logic [2:0]             i_press,
	input  audio_pkg::sram_req_t   i_rec_req,
	input  logic [ADDR_W-1:0]      i_play_addr,
	input  logic                   i_rec_full,
	input  logic                   i_play_end,
	input  logic [ADDR_W:0]        i_rec_len,
	input  logic                   i_rec_stb,
	input  logic                   i_dac_stb,
	output audio_pkg::ctrl_state_t o_state,
	output logic                   o_rec_start,
	output logic                   o_play_start,
	output audio_pkg::sram_req_t   o_sram_req,
	output logic [5:0]             o_rec_time,
	output logic [5:0]             o_play_time
);
	import audio_pkg::*;

	localparam int CNT_W = (TICK_SAMPLES > 1) ? $clog2(TICK_SAMPLES) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(TICK_SAMPLES - 1);

	ctrl_state_t      state_r;
	ctrl_state_t      state_w;
	logic             key_rec;
	logic             key_play;
	logic             key_stop;
	logic [CNT_W-1:0] rec_cnt_r;
	logic [CNT_W-1:0] play_cnt_r;

	assign key_rec  = i_press[KEY_REC];
	assign key_play = i_press[KEY_PLAY];
	assign key_stop = i_press[KEY_STOP];

	assign o_state = state_r;

	// start pulses line up with the edge that enters the new state
	assign o_rec_start  = (state_r == ST_IDLE) && key_rec;
	assign o_play_start = (state_r == ST_IDLE) && !key_rec && key_play && (i_rec_len != '0);

	always_comb begin
		state_w = state_r;
		case (state_r)
			ST_IDLE: begin
				if (o_rec_start) begin
					state_w = ST_RECORD;
				end else if (o_play_start) begin
					state_w = ST_PLAY;
				end
			end
			ST_RECORD: begin
				if (i_rec_full || key_stop) begin
					state_w = ST_IDLE;
				end else if (key_rec) begin
					state_w = ST_REC_PAUSE;
				end
			end
			ST_REC_PAUSE: begin
				if (key_stop) begin
					state_w = ST_IDLE;
				end else if (key_rec) begin
					state_w = ST_RECORD;
				end
			end
			ST_PLAY: begin
				if (i_play_end || key_stop) begin
					state_w = ST_IDLE;
				end else if (key_play) begin
					state_w = ST_PLAY_PAUSE;
				end
			end
			ST_PLAY_PAUSE: begin
				if (key_stop) begin
					state_w = ST_IDLE;
				end else if (key_play) begin
					state_w = ST_PLAY;
				end
			end
			default: state_w = ST_IDLE;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state_r <= ST_IDLE;
		end else begin
			state_r <= state_w;
		end
	end

	// recorder owns the port only while recording
	always_comb begin
		if (state_r == ST_RECORD) begin
			o_sram_req = i_rec_req;
		end else begin
			o_sram_req = '{we_n: 1'b1, addr: SRAM_ADDR_W'(i_play_addr), wdata: '0};
		end
	end

	// elapsed time, one tick per TICK_SAMPLES samples
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			rec_cnt_r  <= '0;
			o_rec_time <= 6'd0;
		end else if (o_rec_start) begin
			rec_cnt_r  <= '0;
			o_rec_time <= 6'd0;
		end else if (i_rec_stb) begin
			if (rec_cnt_r == CNT_LAST) begin
				rec_cnt_r  <= '0;
				o_rec_time <= o_rec_time + 6'd1;
			end else begin
				rec_cnt_r <= rec_cnt_r + 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			play_cnt_r  <= '0;
			o_play_time <= 6'd0;
		end else if (o_play_start) begin
			play_cnt_r  <= '0;
			o_play_time <= 6'd0;
		end else if (i_dac_stb) begin
			if (play_cnt_r == CNT_LAST) begin
				play_cnt_r  <= '0;
				o_play_time <= o_play_time + 6'd1;
			end else begin
				play_cnt_r <= play_cnt_r + 1'b1;
			end
		end
	end

	// a write needs a strobe taken in record one cycle before
	a_write_in_record: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!o_sram_req.we_n |-> (state_r == ST_RECORD) && ($past(state_r) == ST_RECORD));

endmodule

`default_nettype wire

// File: source/audio_dsp.sv
`timescale 1ns/10ps
`default_nettype none

module audio_dsp #(
	parameter int ADDR_W = 20
) (
	input  logic                   i_clk,
	input  logic                   i_rst_n,
	input  audio_pkg::ctrl_state_t i_state,
	input  logic                   i_start,
	input  audio_pkg::play_cfg_t   i_cfg,
	input  logic [ADDR_W:0]        i_len,
	input  logic                   i_sample_stb,
	input  audio_pkg::sample_t     i_rdata,
	output logic [ADDR_W-1:0]      o_addr,
	output logic                   o_dac_stb,
	output audio_pkg::sample_t     o_dac_sample,
	output logic                   o_end
);
	import audio_pkg::*;

	logic [ADDR_W:0]    pos_q;
	logic [3:0]         k_q;
	logic               rd0_q;
	logic               rd1_q;
	sample_t            s0_q;
	logic               playing;
	logic [3:0]         spd;
	logic [ADDR_W:0]    pos_inc;
	logic [ADDR_W:0]    addr1;
	logic [4:0]         k_inc;
	logic               k_wrap;
	logic [3:0]         step;
	logic [ADDR_W+1:0]  pos_next;
	logic signed [16:0] diff;
	logic signed [21:0] prod;
	logic signed [21:0] quo;
	sample_t            out_sample;

	assign playing = (i_state == ST_PLAY);
	assign spd     = (i_cfg.speed == 4'd0) ? 4'd1 : i_cfg.speed;

	// second read stays on the last sample at the end of the recording
	assign pos_inc = pos_q + 1'b1;
	assign addr1   = (pos_inc < i_len) ? pos_inc : pos_q;
	assign o_addr  = rd1_q ? addr1[ADDR_W-1:0] : pos_q[ADDR_W-1:0];

	// sub-step within one source sample for slow play
	assign k_inc  = {1'b0, k_q} + 5'd1;
	assign k_wrap = (k_inc >= {1'b0, spd});

	always_comb begin
		case (i_cfg.mode)
			PLAY_NORMAL: step = 4'd1;
			PLAY_FAST:   step = spd;
			default:     step = k_wrap ? 4'd1 : 4'd0;
		endcase
	end

	assign pos_next = {1'b0, pos_q} + (ADDR_W+2)'(step);

	// s1 comes straight off the sram during the second read
	assign diff = {i_rdata[15], i_rdata} - {s0_q[15], s0_q};
	assign prod = diff * $signed({2'b00, k_q});
	// signed divide truncates toward zero
	assign quo  = prod / $signed({2'b00, spd});

	assign out_sample = (i_cfg.mode == PLAY_SLOW_LIN) ? sample_t'(s0_q + quo[15:0]) : s0_q;

	// strobe -> read p -> read p+1 -> dac strobe, dropped if play is left midway
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			pos_q     <= '0;
			k_q       <= 4'd0;
			rd0_q     <= 1'b0;
			rd1_q     <= 1'b0;
			o_dac_stb <= 1'b0;
			o_end     <= 1'b0;
		end else begin
			rd0_q     <= i_sample_stb && playing;
			rd1_q     <= rd0_q && playing;
			o_dac_stb <= rd1_q && playing;
			o_end     <= rd1_q && playing && (pos_next >= {1'b0, i_len});
			if (i_start) begin
				pos_q <= '0;
				k_q   <= 4'd0;
			end else if (rd1_q && playing) begin
				pos_q <= pos_next[ADDR_W:0];
				if (i_cfg.mode == PLAY_NORMAL || i_cfg.mode == PLAY_FAST) begin
					k_q <= 4'd0;
				end else begin
					k_q <= k_wrap ? 4'd0 : k_inc[3:0];
				end
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (rd0_q) begin
			s0_q <= i_rdata;
		end
		if (rd1_q) begin
			o_dac_sample <= out_sample;
		end
	end

	// reads never run past what the recorder has stored
	a_addr_in_range: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(rd0_q || rd1_q) |-> ({1'b0, o_addr} < i_len));

endmodule

`default_nettype wire

// File: source/audio_pkg.sv
`default_nettype none

package audio_pkg;

	// widest address the sram port can carry
	localparam int SRAM_ADDR_W = 20;

	// bit positions in the key press vector
	localparam int KEY_REC  = 0;
	localparam int KEY_PLAY = 1;
	localparam int KEY_STOP = 2;

	typedef logic signed [15:0] sample_t;

	typedef enum logic [1:0] {
		PLAY_NORMAL     = 2'd0,
		PLAY_FAST       = 2'd1,
		PLAY_SLOW_CONST = 2'd2,
		PLAY_SLOW_LIN   = 2'd3
	} play_mode_t;

	// speed 1..8, zero behaves as 1
	typedef struct packed {
		play_mode_t mode;
		logic [3:0] speed;
	} play_cfg_t;

	typedef enum logic [2:0] {
		ST_IDLE       = 3'd0,
		ST_RECORD     = 3'd1,
		ST_REC_PAUSE  = 3'd2,
		ST_PLAY       = 3'd3,
		ST_PLAY_PAUSE = 3'd4
	} ctrl_state_t;

	// unused upper address bits are kept at zero
	typedef struct packed {
		logic                   we_n;
		logic [SRAM_ADDR_W-1:0] addr;
		sample_t                wdata;
	} sram_req_t;

endpackage

`default_nettype wire

// File: source/audio_recorder.sv
`timescale 1ns/10ps
`default_nettype none

module audio_recorder #(
	parameter int ADDR_W = 20
) (
	input  logic                   i_clk,
	input  logic                   i_rst_n,
	input  audio_pkg::ctrl_state_t i_state,
	input  logic                   i_start,
	input  logic                   i_sample_stb,
	input  audio_pkg::sample_t     i_sample,
	output audio_pkg::sram_req_t   o_req,
	output logic [ADDR_W:0]        o_len,
	output logic                   o_full
);
	import audio_pkg::*;

	logic [ADDR_W:0] wr_ptr;
	logic            pend_q;
	sample_t         data_q;
	logic            wr_en;
	logic            last_addr;
	logic            full_seen;

	// a captured sample is only written while still recording
	assign wr_en     = pend_q && (i_state == ST_RECORD);
	assign last_addr = (wr_ptr[ADDR_W-1:0] == {ADDR_W{1'b1}});

	assign o_req = '{
		we_n:  !wr_en,
		addr:  SRAM_ADDR_W'(wr_ptr[ADDR_W-1:0]),
		wdata: data_q
	};

	// pointer doubles as the recorded length
	assign o_len = wr_ptr;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			wr_ptr <= '0;
			pend_q <= 1'b0;
			o_full <= 1'b0;
		end else begin
			// top pointer bit set means memory is full
			pend_q <= i_sample_stb && (i_state == ST_RECORD) && !wr_ptr[ADDR_W];
			o_full <= wr_en && last_addr;
			if (i_start) begin
				wr_ptr <= '0;
			end else if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_sample_stb) begin
			data_q <= i_sample;
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			full_seen <= 1'b0;
		end else if (i_start) begin
			full_seen <= 1'b0;
		end else if (o_full) begin
			full_seen <= 1'b1;
		end
	end

	// once full, stay silent on the bus until a new recording starts
	a_no_write_after_full: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		full_seen |-> o_req.we_n);

endmodule

`default_nettype wire

// File: source/audio_top.sv
`timescale 1ns/10ps
`default_nettype none

module audio_top #(
	parameter int ADDR_W       = 20,
	parameter int TICK_SAMPLES = 48000
) (
	input  logic                   i_clk,
	input  logic                   i_rst_n,
	input  logic                   i_key_rec,
	input  logic                   i_key_play,
	input  logic                   i_key_stop,
	input  audio_pkg::play_cfg_t   i_play_cfg,
	input  logic                   i_sample_stb,
	input  audio_pkg::sample_t     i_adc_sample,
	input  audio_pkg::sample_t     i_sram_rdata,
	output audio_pkg::sram_req_t   o_sram_req,
	output logic                   o_dac_stb,
	output audio_pkg::sample_t     o_dac_sample,
	output audio_pkg::ctrl_state_t o_state,
	output logic [5:0]             o_rec_time,
	output logic [5:0]             o_play_time
);
	import audio_pkg::*;

	logic [2:0]        keys;
	logic [2:0]        press;
	ctrl_state_t       state;
	logic              rec_start;
	logic              play_start;
	sram_req_t         rec_req;
	logic [ADDR_W:0]   rec_len;
	logic              rec_full;
	logic              rec_stb;
	logic [ADDR_W-1:0] play_addr;
	logic              play_end;

	assign keys[KEY_REC]  = i_key_rec;
	assign keys[KEY_PLAY] = i_key_play;
	assign keys[KEY_STOP] = i_key_stop;

	assign rec_stb = !rec_req.we_n;
	assign o_state = state;

	key_edge_detect key_i (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_keys  (keys),
		.o_press (press)
	);

	audio_ctrl #(
		.ADDR_W       (ADDR_W),
		.TICK_SAMPLES (TICK_SAMPLES)
	) ctrl_i (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_press      (press),
		.i_rec_req    (rec_req),
		.i_play_addr  (play_addr),
		.i_rec_full   (rec_full),
		.i_play_end   (play_end),
		.i_rec_len    (rec_len),
		.i_rec_stb    (rec_stb),
		.i_dac_stb    (o_dac_stb),
		.o_state      (state),
		.o_rec_start  (rec_start),
		.o_play_start (play_start),
		.o_sram_req   (o_sram_req),
		.o_rec_time   (o_rec_time),
		.o_play_time  (o_play_time)
	);

	audio_recorder #(
		.ADDR_W (ADDR_W)
	) rec_i (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_state      (state),
		.i_start      (rec_start),
		.i_sample_stb (i_sample_stb),
		.i_sample     (i_adc_sample),
		.o_req        (rec_req),
		.o_len        (rec_len),
		.o_full       (rec_full)
	);

	audio_dsp #(
		.ADDR_W (ADDR_W)
	) dsp_i (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_state      (state),
		.i_start      (play_start),
		.i_cfg        (i_play_cfg),
		.i_len        (rec_len),
		.i_sample_stb (i_sample_stb),
		.i_rdata      (i_sram_rdata),
		.o_addr       (play_addr),
		.o_dac_stb    (o_dac_stb),
		.o_dac_sample (o_dac_sample),
		.o_end        (play_end)
	);

endmodule

`default_nettype wire

// File: source/key_edge_detect.sv
`timescale 1ns/10ps
`default_nettype none

module key_edge_detect (
	input  logic       i_clk,
	input  logic       i_rst_n,
	input  logic [2:0] i_keys,
	output logic [2:0] o_press
);

	logic [2:0] sync1_q;
	logic [2:0] sync2_q;
	logic [2:0] prev_q;

	// two flop synchroniser, then rising edge against the previous value
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			sync1_q <= 3'b000;
			sync2_q <= 3'b000;
			prev_q  <= 3'b000;
			o_press <= 3'b000;
		end else begin
			sync1_q <= i_keys;
			sync2_q <= sync1_q;
			prev_q  <= sync2_q;
			o_press <= sync2_q & ~prev_q;
		end
	end

	// a held key must give a single pulse only
	a_press_single: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(o_press & $past(o_press)) == 3'b000);

endmodule

`default_nettype wire

// File: verif/audio_tb.sv
`timescale 1ns/10ps
`default_nettype none

module audio_tb;
	import audio_pkg::*;

	localparam int ADDR_W       = 8;
	localparam int TICK_SAMPLES = 16;
	localparam int DEPTH        = 1 << ADDR_W;
	localparam int HALF_PERIOD  = 20;
	localparam int RUN_LIMIT_NS = 5_000_000;

	logic        clk;
	logic        rst_n;
	logic [2:0]  keys;
	play_cfg_t   play_cfg;
	logic        sample_stb;
	sample_t     adc_sample;
	sample_t     sram_rdata;
	sram_req_t   sram_req;
	logic        dac_stb;
	sample_t     dac_sample;
	ctrl_state_t state;
	logic [5:0]  rec_time;
	logic [5:0]  play_time;

	// reference model
	sample_t     mem_m [DEPTH];
	ctrl_state_t state_m;
	int          len_m;
	int          pos_m;
	int          k_m;
	int          writes_m;
	int          outs_m;
	int          seed;

	audio_top #(
		.ADDR_W       (ADDR_W),
		.TICK_SAMPLES (TICK_SAMPLES)
	) dut_i (
		.i_clk        (clk),
		.i_rst_n      (rst_n),
		.i_key_rec    (keys[KEY_REC]),
		.i_key_play   (keys[KEY_PLAY]),
		.i_key_stop   (keys[KEY_STOP]),
		.i_play_cfg   (play_cfg),
		.i_sample_stb (sample_stb),
		.i_adc_sample (adc_sample),
		.i_sram_rdata (sram_rdata),
		.o_sram_req   (sram_req),
		.o_dac_stb    (dac_stb),
		.o_dac_sample (dac_sample),
		.o_state      (state),
		.o_rec_time   (rec_time),
		.o_play_time  (play_time)
	);

	sram_model #(
		.ADDR_W (ADDR_W)
	) sram_i (
		.i_req   (sram_req),
		.o_rdata (sram_rdata)
	);

	always #(HALF_PERIOD) clk = ~clk;

	task automatic abort_run();
		$display("Regression failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			$display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	// strobe spacing of 4 to 8 cycles
	function automatic int next_gap();
		return 4 + ($unsigned($random(seed)) % 5);
	endfunction

	task automatic set_config(input play_mode_t mode);
		play_cfg.mode  = mode;
		play_cfg.speed = 4'($unsigned($random(seed)) % 9);
	endtask

	task automatic press_key(input int which);
		ctrl_state_t from_state;
		ctrl_state_t to_state;
		from_state = state_m;
		to_state   = state_m;
		case (state_m)
			ST_IDLE: begin
				if (which == KEY_REC) begin
					to_state = ST_RECORD;
				end else if (which == KEY_PLAY && len_m != 0) begin
					to_state = ST_PLAY;
				end
			end
			ST_RECORD, ST_REC_PAUSE: begin
				if (which == KEY_STOP) begin
					to_state = ST_IDLE;
				end else if (which == KEY_REC) begin
					to_state = (state_m == ST_RECORD) ? ST_REC_PAUSE : ST_RECORD;
				end
			end
			default: begin
				if (which == KEY_STOP) begin
					to_state = ST_IDLE;
				end else if (which == KEY_PLAY) begin
					to_state = (state_m == ST_PLAY) ? ST_PLAY_PAUSE : ST_PLAY;
				end
			end
		endcase
		keys[which] = 1'b1;
		// pulse after three cycles, new state on the fourth
		for (int i = 1; i <= 4; i++) begin
			@(negedge clk);
			check_value("o_sram_req.we_n", sram_req.we_n, 1'b1);
			check_value("o_dac_stb", dac_stb, 1'b0);
			check_value("o_state", state, (i < 4) ? from_state : to_state);
			if (i == 2) begin
				keys = 3'b000;
			end
		end
		if (from_state == ST_IDLE && to_state == ST_RECORD) begin
			len_m    = 0;
			writes_m = 0;
		end
		if (from_state == ST_IDLE && to_state == ST_PLAY) begin
			pos_m  = 0;
			k_m    = 0;
			outs_m = 0;
		end
		state_m = to_state;
	endtask

	task automatic record_model(input sample_t smp);
		mem_m[len_m] = smp;
		len_m++;
		writes_m++;
		if (len_m == DEPTH) begin
			state_m = ST_IDLE;
		end
	endtask

	task automatic play_model(output sample_t out);
		int s0;
		int s1;
		int spd;
		int quo;
		s0  = mem_m[pos_m];
		s1  = (pos_m + 1 < len_m) ? mem_m[pos_m + 1] : mem_m[pos_m];
		spd = (play_cfg.speed == 4'd0) ? 1 : int'(play_cfg.speed);
		out = sample_t'(s0);
		case (play_cfg.mode)
			PLAY_NORMAL: begin
				pos_m += 1;
				k_m = 0;
			end
			PLAY_FAST: begin
				pos_m += spd;
				k_m = 0;
			end
			default: begin
				if (play_cfg.mode == PLAY_SLOW_LIN) begin
					// integer division truncates toward zero
					quo = ((s1 - s0) * k_m) / spd;
					out = sample_t'(s0 + quo);
				end
				if (k_m + 1 >= spd) begin
					k_m = 0;
					pos_m += 1;
				end else begin
					k_m += 1;
				end
			end
		endcase
		outs_m++;
		if (pos_m >= len_m) begin
			state_m = ST_IDLE;
		end
	endtask

	task automatic send_sample();
		sample_t smp;
		sample_t exp_out;
		int      gap;
		int      wr_addr;
		int      rd_addr0;
		int      rd_addr1;
		logic    exp_write;
		logic    exp_dac;
		smp       = sample_t'($random(seed));
		gap       = next_gap();
		exp_write = (state_m == ST_RECORD);
		exp_dac   = (state_m == ST_PLAY);
		wr_addr   = len_m;
		rd_addr0  = pos_m;
		rd_addr1  = (pos_m + 1 < len_m) ? pos_m + 1 : pos_m;
		exp_out   = '0;
		if (exp_write) begin
			record_model(smp);
		end
		if (exp_dac) begin
			play_model(exp_out);
		end
		sample_stb = 1'b1;
		adc_sample = smp;
		for (int i = 1; i <= gap; i++) begin
			@(negedge clk);
			check_value("o_sram_req.we_n", sram_req.we_n, !(exp_write && i == 1));
			if (exp_write && i == 1) begin
				check_value("o_sram_req.addr", sram_req.addr, wr_addr);
				check_value("o_sram_req.wdata", sram_req.wdata, smp);
			end
			if (exp_dac && i <= 2) begin
				check_value("o_sram_req.addr", sram_req.addr, (i == 1) ? rd_addr0 : rd_addr1);
			end
			check_value("o_dac_stb", dac_stb, exp_dac && i == 3);
			if (exp_dac && i == 3) begin
				check_value("o_dac_sample", dac_sample, exp_out);
			end
			if (i == 1) begin
				sample_stb = 1'b0;
			end
		end
		check_value("o_state", state, state_m);
		check_value("o_rec_time", rec_time, (writes_m / TICK_SAMPLES) % 64);
		check_value("o_play_time", play_time, (outs_m / TICK_SAMPLES) % 64);
	endtask

	task automatic play_to_end();
		int count;
		count = 0;
		while (state_m == ST_PLAY) begin
			if (count > 8 * DEPTH) begin
				$display("timeout: playback did not reach the end of the recording");
				abort_run();
			end
			send_sample();
			count++;
		end
	endtask

	task automatic record_to_full();
		int count;
		count = 0;
		while (state_m == ST_RECORD) begin
			if (count > DEPTH + 8) begin
				$display("timeout: recording did not fill the memory");
				abort_run();
			end
			send_sample();
			count++;
		end
	endtask

	// run length guard
	initial begin
		#(RUN_LIMIT_NS);
		$display("timeout: simulation ran past its time limit");
		abort_run();
	end

	initial begin
		seed       = 32'h45ae;
		clk        = 1'b0;
		rst_n      = 1'b0;
		keys       = 3'b000;
		play_cfg   = '{mode: PLAY_NORMAL, speed: 4'd1};
		sample_stb = 1'b0;
		adc_sample = '0;
		state_m    = ST_IDLE;
		len_m      = 0;
		pos_m      = 0;
		k_m        = 0;
		writes_m   = 0;
		outs_m     = 0;
		repeat (5) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_value("o_state", state, ST_IDLE);
		check_value("o_sram_req.we_n", sram_req.we_n, 1'b1);
		check_value("o_dac_stb", dac_stb, 1'b0);
		check_value("o_rec_time", rec_time, 0);
		check_value("o_play_time", play_time, 0);

		// record, pause, resume, stop
		press_key(KEY_REC);
		repeat (20) send_sample();
		press_key(KEY_REC);
		repeat (3) send_sample();
		press_key(KEY_REC);
		repeat (10) send_sample();
		press_key(KEY_STOP);

		// normal play with a pause in the middle
		set_config(PLAY_NORMAL);
		press_key(KEY_PLAY);
		repeat (8) send_sample();
		press_key(KEY_PLAY);
		repeat (3) send_sample();
		press_key(KEY_PLAY);
		play_to_end();

		// stop mid play, then a full fast pass
		set_config(PLAY_FAST);
		press_key(KEY_PLAY);
		repeat (2) send_sample();
		press_key(KEY_STOP);
		press_key(KEY_PLAY);
		play_to_end();

		set_config(PLAY_SLOW_CONST);
		press_key(KEY_PLAY);
		play_to_end();
		set_config(PLAY_SLOW_LIN);
		press_key(KEY_PLAY);
		play_to_end();

		// fill the whole memory, then read it all back
		press_key(KEY_REC);
		record_to_full();
		repeat (3) send_sample();
		set_config(PLAY_NORMAL);
		press_key(KEY_PLAY);
		play_to_end();

		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/sram_model.sv
`timescale 1ns/10ps
`default_nettype none

module sram_model #(
	parameter int ADDR_W = 8
) (
	input  audio_pkg::sram_req_t i_req,
	output audio_pkg::sample_t   o_rdata
);
	import audio_pkg::*;

	localparam int DEPTH = 1 << ADDR_W;

	sample_t mem [DEPTH];

	// fill pattern spreads every address bit over the word
	initial begin
		for (int a = 0; a < DEPTH; a++) begin
			mem[a] = sample_t'((a * 40503) ^ (a << 9) ^ 16'h5a5a);
		end
	end

	// write lands inside the low pulse once address and data have settled
	always @(negedge i_req.we_n) begin
		#1;
		if (!i_req.we_n) begin
			mem[i_req.addr[ADDR_W-1:0]] = i_req.wdata;
		end
	end

	// asynchronous read
	assign o_rdata = mem[i_req.addr[ADDR_W-1:0]];

endmodule

`default_nettype wire
